//--- Bender.yml
package:
  name: null_src_sink

sources:
  # Packages first, then the RTL leaves and the top level
  - hdl/chdr_pkg.sv
  - hdl/null_src_sink_pkg.sv
  - hdl/stream_counter.sv
  - hdl/null_source.sv
  - hdl/null_reg_file.sv
  - hdl/null_src_sink_block.sv
  - target: simulation
    files:
      - dv/null_src_sink_tb.sv

//--- compile.f
hdl/chdr_pkg.sv
hdl/null_src_sink_pkg.sv
hdl/stream_counter.sv
hdl/null_source.sv
hdl/null_reg_file.sv
hdl/null_src_sink_block.sv
dv/null_src_sink_tb.sv

//--- dv/null_src_sink_tb.sv
// Table-driven testbench for the null source/sink block
// Stops at the first mismatch, with a watchdog sized from the table length
`timescale 1ns/1ns

module null_src_sink_tb;

  import chdr_pkg::*;
  import null_src_sink_pkg::*;

  typedef enum logic [2:0] {
    op_write, op_read, op_sink, op_loop, op_source, op_idle
  } op_t;

  // arg is an address or packet count, val is write data or base length
  typedef struct packed {
    op_t         op;
    logic [31:0] arg;
    logic [31:0] val;
    logic [31:0] exp;
  } row_t;

  localparam int n_rows = 39;

  row_t rows [n_rows] = '{
    '{op_write,  32'h04, 32'hFFFF_F003, 32'h0},
    '{op_read,   32'h04, 32'h0,         32'h0000_0003},
    '{op_write,  32'h08, 32'h1234_0020, 32'h0},
    '{op_read,   32'h08, 32'h0,         32'h0000_0020},
    '{op_write,  32'h0C, 32'hFFFF_FC05, 32'h0},
    '{op_read,   32'h0C, 32'h0,         32'h0000_0005},
    '{op_read,   32'h00, 32'h0,         32'h0220_0000},
    '{op_read,   32'h44, 32'h0,         32'h0},
    '{op_write,  32'h00, 32'h1,         32'h0},
    '{op_read,   32'h00, 32'h0,         32'h0220_0001},
    '{op_write,  32'h00, 32'h0,         32'h0},
    '{op_sink,   32'd3,  32'd2,         32'h0},
    '{op_read,   32'h10, 32'h0,         32'h0},
    '{op_read,   32'h18, 32'h0,         32'h0},
    '{op_loop,   32'd3,  32'd3,         32'h0},
    '{op_read,   32'h30, 32'h0,         32'h0},
    '{op_read,   32'h38, 32'h0,         32'h0},
    '{op_write,  32'h00, 32'h2,         32'h0},
    '{op_read,   32'h00, 32'h0,         32'h0220_0002},
    '{op_source, 32'd3,  32'h0,         32'h0},
    '{op_read,   32'h20, 32'h0,         32'h0},
    '{op_read,   32'h28, 32'h0,         32'h0},
    '{op_read,   32'h2C, 32'h0,         32'h0},
    '{op_write,  32'h00, 32'h1,         32'h0},
    '{op_read,   32'h10, 32'h0,         32'h0},
    '{op_read,   32'h18, 32'h0,         32'h0},
    '{op_read,   32'h20, 32'h0,         32'h0},
    '{op_read,   32'h28, 32'h0,         32'h0},
    '{op_read,   32'h30, 32'h0,         32'h0},
    '{op_read,   32'h38, 32'h0,         32'h0},
    '{op_write,  32'h00, 32'h0,         32'h0},
    '{op_sink,   32'd2,  32'd1,         32'h0},
    '{op_read,   32'h18, 32'h0,         32'h0},
    '{op_write,  32'h04, 32'h1,         32'h0},
    '{op_write,  32'h00, 32'h2,         32'h0},
    '{op_source, 32'd2,  32'h0,         32'h0},
    '{op_read,   32'h20, 32'h0,         32'h0},
    '{op_idle,   32'd4,  32'h0,         32'h0},
    '{op_read,   32'h00, 32'h0,         32'h0220_0000}
  };

  logic        clk;
  logic        rst;
  logic [63:0] s0_tdata, s1_tdata, m0_tdata, m1_tdata;
  logic        s0_tlast, s0_tvalid, s0_tready;
  logic        s1_tlast, s1_tvalid, s1_tready;
  logic        m0_tlast, m0_tvalid, m0_tready;
  logic        m1_tlast, m1_tvalid, m1_tready;
  logic        ctrl_req_wr, ctrl_req_rd, ctrl_resp_ack;
  logic [19:0] ctrl_req_addr;
  logic [31:0] ctrl_req_data, ctrl_resp_data;

  // Reference model state
  logic [63:0] snk_lines = '0, snk_pkts = '0;
  logic [63:0] src_lines = '0, src_pkts = '0;
  logic [63:0] loop_lines = '0, loop_pkts = '0;
  logic [11:0] model_lpp = '0;
  logic [15:0] model_bpp = '0;
  logic [64:0] sent_q [$];
  logic [15:0] lfsr = 16'd16384;
  int          hdr_seen;

  null_src_sink_block dut_i (
    .rfnoc_chdr_clk(clk), .rfnoc_chdr_rst(rst),
    .s0_tdata, .s0_tlast, .s0_tvalid, .s0_tready,
    .s1_tdata, .s1_tlast, .s1_tvalid, .s1_tready,
    .m0_tdata, .m0_tlast, .m0_tvalid, .m0_tready,
    .m1_tdata, .m1_tlast, .m1_tvalid, .m1_tready,
    .ctrl_req_wr, .ctrl_req_rd, .ctrl_req_addr, .ctrl_req_data,
    .ctrl_resp_ack, .ctrl_resp_data
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(n_rows * 4000);
    $display("Timeout: the test table did not finish within %0d ns", n_rows * 4000);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // Helpers
  // ----------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_word(input int n);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic [31:0] model_count(input logic [19:0] addr);
    case (addr)
      reg_snk_line_cnt_lo:  return snk_lines[31:0];
      reg_snk_line_cnt_hi:  return snk_lines[63:32];
      reg_snk_pkt_cnt_lo:   return snk_pkts[31:0];
      reg_snk_pkt_cnt_hi:   return snk_pkts[63:32];
      reg_src_line_cnt_lo:  return src_lines[31:0];
      reg_src_line_cnt_hi:  return src_lines[63:32];
      reg_src_pkt_cnt_lo:   return src_pkts[31:0];
      reg_src_pkt_cnt_hi:   return src_pkts[63:32];
      reg_loop_line_cnt_lo: return loop_lines[31:0];
      reg_loop_line_cnt_hi: return loop_lines[63:32];
      reg_loop_pkt_cnt_lo:  return loop_pkts[31:0];
      reg_loop_pkt_cnt_hi:  return loop_pkts[63:32];
      default:              return 32'd0;
    endcase
  endfunction

  task automatic expect_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Bus tasks, all entered 2 ns after a rising edge
  // ----------------------------------------
  task automatic ctrl_access(input logic wr, input logic [19:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    ctrl_req_wr   = wr;
    ctrl_req_rd   = !wr;
    ctrl_req_addr = addr;
    ctrl_req_data = wdata;
    @(negedge clk);
    expect_equal(ctrl_resp_ack, 1'b0, "ack during request cycle");
    next_cycle();
    ctrl_req_wr = 1'b0;
    ctrl_req_rd = 1'b0;
    @(negedge clk);
    expect_equal(ctrl_resp_ack, 1'b1, "ack one cycle after request");
    rdata = ctrl_resp_data;
    next_cycle();
    expect_equal(ctrl_resp_ack, 1'b0, "ack longer than one cycle");
    if (wr) begin
      case (addr)
        reg_ctrl_status: begin
          if (wdata[0]) begin
            snk_lines = '0;
            snk_pkts  = '0;
            src_lines = '0;
            src_pkts  = '0;
            loop_lines = '0;
            loop_pkts  = '0;
          end
        end
        reg_src_lines_per_pkt: model_lpp = wdata[11:0];
        reg_src_bytes_per_pkt: model_bpp = wdata[15:0];
        default: begin
        end
      endcase
    end
  endtask

  task automatic send_sink(input int n_pkts, input int base_len);
    int len;
    for (int p = 0; p < n_pkts; p++) begin
      len = base_len + p;
      for (int b = 0; b < len; b++) begin
        while (lfsr_bit()) begin
          s0_tvalid = 1'b0;
          next_cycle();
        end
        s0_tvalid = 1'b1;
        s0_tdata  = rand_word(64);
        s0_tlast  = (b == len - 1);
        @(negedge clk);
        expect_equal(s0_tready, 1'b1, "sink ready");
        snk_lines++;
        if (s0_tlast) snk_pkts++;
        next_cycle();
      end
    end
    s0_tvalid = 1'b0;
    s0_tlast  = 1'b0;
  endtask

  task automatic send_loop(input int n_pkts, input int base_len);
    int          len;
    logic        done;
    logic [64:0] beat;
    for (int p = 0; p < n_pkts; p++) begin
      len = base_len + p;
      for (int b = 0; b < len; b++) begin
        while (lfsr_bit()) begin
          s1_tvalid = 1'b0;
          next_cycle();
        end
        s1_tvalid = 1'b1;
        s1_tdata  = rand_word(64);
        s1_tlast  = (b == len - 1);
        sent_q.push_back({s1_tlast, s1_tdata});
        done = 1'b0;
        while (!done) begin
          m1_tready = lfsr_bit();
          @(negedge clk);
          expect_equal(s1_tready, m1_tready, "loop ready pass-through");
          expect_equal(m1_tvalid, 1'b1, "loop valid");
          if (m1_tready) begin
            beat = sent_q.pop_front();
            expect_equal(m1_tlast, beat[64], "loop tlast");
            expect_equal(m1_tdata, beat[63:0], "loop data");
            loop_lines++;
            if (beat[64]) loop_pkts++;
            done = 1'b1;
          end
          next_cycle();
        end
      end
    end
    s1_tvalid = 1'b0;
    s1_tlast  = 1'b0;
  endtask

  // Header is beat 0, payload beats follow, last one at beat L + 1
  task automatic capture_source(input int n_pkts);
    int          beat;
    int          pkts;
    logic        last;
    logic [15:0] lc;
    beat = 0;
    pkts = 0;
    while (pkts < n_pkts) begin
      m0_tready = lfsr_bit();
      @(negedge clk);
      if (m0_tvalid && m0_tready) begin
        if (beat == 0) begin
          expect_equal(m0_tlast, 1'b0, "source header tlast");
          expect_equal(m0_tdata, {6'd0, 1'b0, 1'b0, pkt_type_data_no_ts, 5'd0,
                                  src_pkts[15:0], model_bpp, 16'd0}, "source header");
          hdr_seen++;
          beat = 1;
        end else begin
          last = (beat == int'(model_lpp) + 1);
          lc   = src_lines[15:0];
          expect_equal(m0_tlast, last, "source payload tlast");
          expect_equal(m0_tdata, {~lc, lc, ~lc, lc}, "source payload");
          src_lines++;
          beat++;
          if (last) begin
            src_pkts++;
            pkts++;
            beat = 0;
          end
        end
      end
      next_cycle();
    end
  endtask

  // Enable is cleared once the last wanted header has gone out
  task automatic run_source(input int n_pkts);
    logic [31:0] rd_unused;
    hdr_seen = 0;
    fork
      capture_source(n_pkts);
      begin
        wait (hdr_seen == n_pkts);
        next_cycle();
        ctrl_access(1'b1, reg_ctrl_status, 32'd0, rd_unused);
      end
    join
    repeat (16) begin
      m0_tready = lfsr_bit();
      @(negedge clk);
      expect_equal(m0_tvalid, 1'b0, "source quiet after disable");
      next_cycle();
    end
    // No header may slip out before the next capture starts
    m0_tready = 1'b0;
  endtask

  // Main sequence
  // ----------------------------------------
  initial begin
    logic [31:0] rdata;
    logic [31:0] expected;
    rst           = 1'b1;
    s0_tdata      = '0;
    s0_tlast      = 1'b0;
    s0_tvalid     = 1'b0;
    s1_tdata      = '0;
    s1_tlast      = 1'b0;
    s1_tvalid     = 1'b0;
    m0_tready     = 1'b0;
    m1_tready     = 1'b0;
    ctrl_req_wr   = 1'b0;
    ctrl_req_rd   = 1'b0;
    ctrl_req_addr = '0;
    ctrl_req_data = '0;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    expect_equal(m0_tvalid, 1'b0, "source valid after reset");
    expect_equal(ctrl_resp_ack, 1'b0, "ack after reset");

    for (int i = 0; i < n_rows; i++) begin
      case (rows[i].op)
        op_write: ctrl_access(1'b1, rows[i].arg[19:0], rows[i].val, rdata);
        op_read: begin
          ctrl_access(1'b0, rows[i].arg[19:0], 32'd0, rdata);
          if (rows[i].arg >= reg_snk_line_cnt_lo && rows[i].arg <= reg_loop_pkt_cnt_hi) begin
            expected = model_count(rows[i].arg[19:0]);
          end else begin
            expected = rows[i].exp;
          end
          expect_equal(rdata, expected, $sformatf("row %0d read of 0x%0h", i, rows[i].arg));
        end
        op_sink:   send_sink(rows[i].arg, rows[i].val);
        op_loop:   send_loop(rows[i].arg, rows[i].val);
        op_source: run_source(rows[i].arg);
        default: begin
          repeat (rows[i].arg) next_cycle();
        end
      endcase
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- hdl/chdr_pkg.sv
// CHDR bus constants for a fixed 64-bit datapath with two 32-bit items per beat
// Header layout covers the first beat only, with no timestamp and no metadata
package chdr_pkg;

  // Bus geometry
  localparam int chdr_w = 64;
  localparam int item_w = 32;
  localparam int nipc   = chdr_w / item_w;

  // Packet kinds carried in the header type field
  typedef enum logic [2:0] {
    pkt_type_mgmt       = 3'd0,
    pkt_type_strs       = 3'd1,
    pkt_type_strc       = 3'd2,
    pkt_type_ctrl       = 3'd4,
    pkt_type_data_no_ts = 3'd6,
    pkt_type_data_ts    = 3'd7
  } chdr_pkt_type_t;

  // Header field positions
  // ----------------------------------------
  localparam int hdr_vc_msb   = 63;
  localparam int hdr_vc_lsb   = 58;
  localparam int hdr_eob_bit  = 57;
  localparam int hdr_eov_bit  = 56;
  localparam int hdr_type_msb = 55;
  localparam int hdr_type_lsb = 53;
  localparam int hdr_nmd_msb  = 52;
  localparam int hdr_nmd_lsb  = 48;
  // Sequence number and byte length
  localparam int hdr_seq_msb  = 47;
  localparam int hdr_seq_lsb  = 32;
  localparam int hdr_len_msb  = 31;
  localparam int hdr_len_lsb  = 16;
  // Destination endpoint
  localparam int hdr_dst_msb  = 15;
  localparam int hdr_dst_lsb  = 0;

endpackage

//--- hdl/null_reg_file.sv
// Control-port registers; every request is acked one cycle later
// Writes to read-only or unmapped addresses are ignored, unmapped reads return 0
`timescale 1ns/1ns

module null_reg_file (
  input  logic                                      rfnoc_chdr_clk,
  input  logic                                      rfnoc_chdr_rst,
  input  logic                                      ctrl_req_wr,
  input  logic                                      ctrl_req_rd,
  input  logic [19:0]                               ctrl_req_addr,
  input  logic [31:0]                               ctrl_req_data,
  output logic                                      ctrl_resp_ack,
  output logic [31:0]                               ctrl_resp_data,
  output logic                                      src_en,
  output logic                                      clear_cnts,
  output logic [null_src_sink_pkg::lpp_w-1:0]       src_lpp,
  output logic [null_src_sink_pkg::bpp_w-1:0]       src_bpp,
  output logic [null_src_sink_pkg::throttle_w-1:0]  src_throttle,
  input  logic [63:0]                               snk_line_cnt,
  input  logic [63:0]                               snk_pkt_cnt,
  input  logic [63:0]                               src_line_cnt,
  input  logic [63:0]                               src_pkt_cnt,
  input  logic [63:0]                               loop_line_cnt,
  input  logic [63:0]                               loop_pkt_cnt,
  input  null_src_sink_pkg::src_state_t             src_state
);

  import chdr_pkg::*;
  import null_src_sink_pkg::*;

  logic [31:0] status_word;
  logic [31:0] rd_data;

  // Status word assembly
  always_comb begin
    status_word = '0;
    status_word[stat_nipc_lsb +: 8]   = 8'(nipc);
    status_word[stat_item_w_lsb +: 8] = 8'(item_w);
    status_word[stat_state_lsb +: 2]  = src_state;
    status_word[ctrl_en_bit]          = src_en;
    status_word[ctrl_clear_bit]       = clear_cnts;
  end

  // Read mux
  // ----------------------------------------
  always_comb begin
    case (ctrl_req_addr)
      reg_ctrl_status:       rd_data = status_word;
      reg_src_lines_per_pkt: rd_data = 32'(src_lpp);
      reg_src_bytes_per_pkt: rd_data = 32'(src_bpp);
      reg_src_throttle_cyc:  rd_data = 32'(src_throttle);
      reg_snk_line_cnt_lo:   rd_data = snk_line_cnt[31:0];
      reg_snk_line_cnt_hi:   rd_data = snk_line_cnt[63:32];
      reg_snk_pkt_cnt_lo:    rd_data = snk_pkt_cnt[31:0];
      reg_snk_pkt_cnt_hi:    rd_data = snk_pkt_cnt[63:32];
      reg_src_line_cnt_lo:   rd_data = src_line_cnt[31:0];
      reg_src_line_cnt_hi:   rd_data = src_line_cnt[63:32];
      reg_src_pkt_cnt_lo:    rd_data = src_pkt_cnt[31:0];
      reg_src_pkt_cnt_hi:    rd_data = src_pkt_cnt[63:32];
      reg_loop_line_cnt_lo:  rd_data = loop_line_cnt[31:0];
      reg_loop_line_cnt_hi:  rd_data = loop_line_cnt[63:32];
      reg_loop_pkt_cnt_lo:   rd_data = loop_pkt_cnt[31:0];
      reg_loop_pkt_cnt_hi:   rd_data = loop_pkt_cnt[63:32];
      default:               rd_data = 32'd0;
    endcase
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (ctrl_req_rd) begin
      ctrl_resp_data <= rd_data;
    end
  end

  // Write decode and ack
  // ----------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      ctrl_resp_ack <= 1'b0;
      src_en        <= 1'b0;
      clear_cnts    <= 1'b0;
      src_lpp       <= '0;
      src_bpp       <= '0;
      src_throttle  <= '0;
    end else begin
      ctrl_resp_ack <= ctrl_req_wr | ctrl_req_rd;
      if (ctrl_req_wr) begin
        case (ctrl_req_addr)
          reg_ctrl_status: begin
            src_en     <= ctrl_req_data[ctrl_en_bit];
            clear_cnts <= ctrl_req_data[ctrl_clear_bit];
          end
          reg_src_lines_per_pkt: src_lpp      <= ctrl_req_data[lpp_w-1:0];
          reg_src_bytes_per_pkt: src_bpp      <= ctrl_req_data[bpp_w-1:0];
          reg_src_throttle_cyc:  src_throttle <= ctrl_req_data[throttle_w-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  // The master issues one kind of request at a time
  a_one_req: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    !(ctrl_req_wr && ctrl_req_rd));

endmodule

//--- hdl/null_source.sv
// Packet generator: one header beat, then src_lpp + 1 payload beats
// Sequence number and payload pattern come from the external source counter
`timescale 1ns/1ns

module null_source (
  input  logic                                         rfnoc_chdr_clk,
  input  logic                                         rfnoc_chdr_rst,
  input  logic                                         src_en,
  input  logic [null_src_sink_pkg::lpp_w-1:0]          src_lpp,
  input  logic [null_src_sink_pkg::bpp_w-1:0]          src_bpp,
  input  logic [null_src_sink_pkg::throttle_w-1:0]     src_throttle,
  input  logic [63:0]                                  line_cnt,
  input  logic [63:0]                                  pkt_cnt,
  output logic [chdr_pkg::chdr_w-1:0]                  m_tdata,
  output logic                                         m_tlast,
  output logic                                         m_tvalid,
  input  logic                                         m_tready,
  output logic                                         pyld_valid,
  output null_src_sink_pkg::src_state_t                state
);

  import chdr_pkg::*;
  import null_src_sink_pkg::*;

  logic [lpp_w-1:0]      lines_left;
  logic [throttle_w-1:0] throttle_cnt;
  logic [chdr_w-1:0]     hdr;
  logic [chdr_w-1:0]     pyld;
  logic [chdr_w-1:0]     data_q;
  logic                  stall_q;

  // Beat contents
  // ----------------------------------------
  always_comb begin
    hdr = '0;
    hdr[hdr_vc_msb:hdr_vc_lsb]     = 6'd0;
    hdr[hdr_eob_bit]               = 1'b0;
    hdr[hdr_eov_bit]               = 1'b0;
    hdr[hdr_type_msb:hdr_type_lsb] = pkt_type_data_no_ts;
    hdr[hdr_nmd_msb:hdr_nmd_lsb]   = 5'd0;
    hdr[hdr_seq_msb:hdr_seq_lsb]   = pkt_cnt[15:0];
    hdr[hdr_len_msb:hdr_len_lsb]   = src_bpp;
    hdr[hdr_dst_msb:hdr_dst_lsb]   = 16'd0;
  end

  // Each item is the inverted line count above the line count
  assign pyld = {nipc{~line_cnt[item_w/2-1:0], line_cnt[item_w/2-1:0]}};

  // Output stage
  // ----------------------------------------
  // A stalled beat keeps its valid and data even if enable, config or counts move
  assign pyld_valid = (state == st_pyld);
  assign m_tvalid   = stall_q | pyld_valid | ((state == st_hdr) & src_en);
  assign m_tlast    = pyld_valid & (lines_left == '0);

  always_comb begin
    if (stall_q) begin
      m_tdata = data_q;
    end else if (pyld_valid) begin
      m_tdata = pyld;
    end else begin
      m_tdata = hdr;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    data_q <= m_tdata;
  end

  // Header, payload and throttle FSM
  // ----------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state        <= st_hdr;
      stall_q      <= 1'b0;
      lines_left   <= '0;
      throttle_cnt <= '0;
    end else begin
      stall_q <= m_tvalid & ~m_tready;
      case (state)
        st_hdr: begin
          if (m_tvalid && m_tready) begin
            state      <= st_pyld;
            lines_left <= src_lpp;
          end
        end
        st_pyld: begin
          if (m_tready) begin
            if (m_tlast) begin
              if (src_throttle == '0) begin
                state <= st_hdr;
              end else begin
                state        <= st_wait;
                throttle_cnt <= src_throttle;
              end
            end else begin
              lines_left <= lines_left - 1'b1;
            end
          end
        end
        st_wait: begin
          if (throttle_cnt == '0) begin
            state <= st_hdr;
          end else begin
            throttle_cnt <= throttle_cnt - 1'b1;
          end
        end
        default: begin
          state <= st_hdr;
        end
      endcase
    end
  end

  // AXIS hold rule across back-pressure
  a_hold_beat: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

  // Payload only ever follows a header that transferred
  a_pyld_after_hdr: assert property (@(posedge rfnoc_chdr_clk) disable iff (rfnoc_chdr_rst)
    $rose(pyld_valid) |-> $past(state == st_hdr && m_tvalid && m_tready));

endmodule

//--- hdl/null_src_sink_block.sv
// Null source, sink and loopback block with a direct control port
// s0 sinks, s1 loops to m1 with no delay, m0 sources generated packets
`timescale 1ns/1ns

module null_src_sink_block (
  input  logic                        rfnoc_chdr_clk,
  input  logic                        rfnoc_chdr_rst,
  // Sink input
  input  logic [chdr_pkg::chdr_w-1:0] s0_tdata,
  input  logic                        s0_tlast,
  input  logic                        s0_tvalid,
  output logic                        s0_tready,
  // Loopback input
  input  logic [chdr_pkg::chdr_w-1:0] s1_tdata,
  input  logic                        s1_tlast,
  input  logic                        s1_tvalid,
  output logic                        s1_tready,
  // Source output
  output logic [chdr_pkg::chdr_w-1:0] m0_tdata,
  output logic                        m0_tlast,
  output logic                        m0_tvalid,
  input  logic                        m0_tready,
  // Loopback output
  output logic [chdr_pkg::chdr_w-1:0] m1_tdata,
  output logic                        m1_tlast,
  output logic                        m1_tvalid,
  input  logic                        m1_tready,
  // Control port
  input  logic                        ctrl_req_wr,
  input  logic                        ctrl_req_rd,
  input  logic [19:0]                 ctrl_req_addr,
  input  logic [31:0]                 ctrl_req_data,
  output logic                        ctrl_resp_ack,
  output logic [31:0]                 ctrl_resp_data
);

  import null_src_sink_pkg::*;

  logic                  src_en;
  logic                  clear_cnts;
  logic [lpp_w-1:0]      src_lpp;
  logic [bpp_w-1:0]      src_bpp;
  logic [throttle_w-1:0] src_throttle;
  logic                  src_pyld_valid;
  src_state_t            src_state;
  logic [63:0]           snk_line_cnt, snk_pkt_cnt;
  logic [63:0]           src_line_cnt, src_pkt_cnt;
  logic [63:0]           loop_line_cnt, loop_pkt_cnt;

  // Sink drops every beat
  assign s0_tready = 1'b1;

  // Loopback is a straight pass
  assign m1_tdata  = s1_tdata;
  assign m1_tlast  = s1_tlast;
  assign m1_tvalid = s1_tvalid;
  assign s1_tready = m1_tready;

  // Counters
  // ----------------------------------------
  stream_counter snk_cnt_i (
    .rfnoc_chdr_clk, .rfnoc_chdr_rst, .clear(clear_cnts),
    .tvalid(s0_tvalid), .tready(s0_tready), .tlast(s0_tlast),
    .line_cnt(snk_line_cnt), .pkt_cnt(snk_pkt_cnt)
  );

  // Header beats are left out of the source count
  stream_counter src_cnt_i (
    .rfnoc_chdr_clk, .rfnoc_chdr_rst, .clear(clear_cnts),
    .tvalid(src_pyld_valid), .tready(m0_tready), .tlast(m0_tlast),
    .line_cnt(src_line_cnt), .pkt_cnt(src_pkt_cnt)
  );

  stream_counter loop_cnt_i (
    .rfnoc_chdr_clk, .rfnoc_chdr_rst, .clear(clear_cnts),
    .tvalid(s1_tvalid), .tready(s1_tready), .tlast(s1_tlast),
    .line_cnt(loop_line_cnt), .pkt_cnt(loop_pkt_cnt)
  );

  // Source and registers
  // ----------------------------------------
  null_source src_i (
    .rfnoc_chdr_clk, .rfnoc_chdr_rst, .src_en, .src_lpp, .src_bpp, .src_throttle,
    .line_cnt(src_line_cnt), .pkt_cnt(src_pkt_cnt),
    .m_tdata(m0_tdata), .m_tlast(m0_tlast), .m_tvalid(m0_tvalid), .m_tready(m0_tready),
    .pyld_valid(src_pyld_valid), .state(src_state)
  );

  null_reg_file regs_i (
    .rfnoc_chdr_clk, .rfnoc_chdr_rst,
    .ctrl_req_wr, .ctrl_req_rd, .ctrl_req_addr, .ctrl_req_data,
    .ctrl_resp_ack, .ctrl_resp_data,
    .src_en, .clear_cnts, .src_lpp, .src_bpp, .src_throttle,
    .snk_line_cnt, .snk_pkt_cnt, .src_line_cnt, .src_pkt_cnt,
    .loop_line_cnt, .loop_pkt_cnt, .src_state
  );

endmodule

//--- hdl/null_src_sink_pkg.sv
// Register map and source definitions for the null source/sink block
// Addresses are byte addresses on a 20-bit control port, all registers 32 bits
package null_src_sink_pkg;

  // Register map
  // ----------------------------------------
  localparam logic [19:0] reg_ctrl_status       = 20'h00;
  localparam logic [19:0] reg_src_lines_per_pkt = 20'h04;
  localparam logic [19:0] reg_src_bytes_per_pkt = 20'h08;
  localparam logic [19:0] reg_src_throttle_cyc  = 20'h0C;
  localparam logic [19:0] reg_snk_line_cnt_lo   = 20'h10;
  localparam logic [19:0] reg_snk_line_cnt_hi   = 20'h14;
  localparam logic [19:0] reg_snk_pkt_cnt_lo    = 20'h18;
  localparam logic [19:0] reg_snk_pkt_cnt_hi    = 20'h1C;
  localparam logic [19:0] reg_src_line_cnt_lo   = 20'h20;
  localparam logic [19:0] reg_src_line_cnt_hi   = 20'h24;
  localparam logic [19:0] reg_src_pkt_cnt_lo    = 20'h28;
  localparam logic [19:0] reg_src_pkt_cnt_hi    = 20'h2C;
  localparam logic [19:0] reg_loop_line_cnt_lo  = 20'h30;
  localparam logic [19:0] reg_loop_line_cnt_hi  = 20'h34;
  localparam logic [19:0] reg_loop_pkt_cnt_lo   = 20'h38;
  localparam logic [19:0] reg_loop_pkt_cnt_hi   = 20'h3C;

  // Control bits in reg_ctrl_status
  localparam int ctrl_clear_bit = 0;
  localparam int ctrl_en_bit    = 1;

  // Configuration field widths
  localparam int lpp_w      = 12;
  localparam int bpp_w      = 16;
  localparam int throttle_w = 10;

  // Status word layout, upper fields
  localparam int stat_nipc_lsb   = 24;
  localparam int stat_item_w_lsb = 16;
  localparam int stat_state_lsb  = 14;

  // Source FSM states
  typedef enum logic [1:0] {
    st_hdr  = 2'd0,
    st_pyld = 2'd1,
    st_wait = 2'd2
  } src_state_t;

endpackage

//--- hdl/stream_counter.sv
// Beat and packet counter for one valid/ready stream
// Counts wrap at 2^64, clear is a level and holds both counts at zero
`timescale 1ns/1ns

module stream_counter (
  input  logic        rfnoc_chdr_clk,
  input  logic        rfnoc_chdr_rst,
  input  logic        clear,
  input  logic        tvalid,
  input  logic        tready,
  input  logic        tlast,
  output logic [63:0] line_cnt,
  output logic [63:0] pkt_cnt
);

  logic xfer;

  assign xfer = tvalid & tready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || clear) begin
      line_cnt <= 64'd0;
      pkt_cnt  <= 64'd0;
    end else if (xfer) begin
      line_cnt <= line_cnt + 64'd1;
      // Last beat closes a packet
      if (tlast) begin
        pkt_cnt <= pkt_cnt + 64'd1;
      end
    end
  end

endmodule
